//--- common/id_macros.svh
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// Datapath widths
`define ID_WORD_W      32
`define ID_REG_ADDR_W  5

// Return address register for JAL, BLTZAL and BGEZAL
`define ID_LINK_REG    5'd31

// Bytes per instruction
`define ID_PC_STEP     32'd4

`endif

//--- common/id_pkg.sv
`default_nettype none

`include "id_macros.svh"

package id_pkg;

	typedef logic [`ID_WORD_W-1:0]     word_t;
	typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_REGIMM  = 6'b000001,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL     = 6'b000000,
		FN_SRL     = 6'b000010,
		FN_SRA     = 6'b000011,
		FN_SLLV    = 6'b000100,
		FN_SRLV    = 6'b000110,
		FN_SRAV    = 6'b000111,
		FN_JR      = 6'b001000,
		FN_JALR    = 6'b001001,
		FN_SYSCALL = 6'b001100,
		FN_BREAK   = 6'b001101,
		FN_ADD     = 6'b100000,
		FN_ADDU    = 6'b100001,
		FN_SUB     = 6'b100010,
		FN_SUBU    = 6'b100011,
		FN_AND     = 6'b100100,
		FN_OR      = 6'b100101,
		FN_XOR     = 6'b100110,
		FN_NOR     = 6'b100111,
		FN_SLT     = 6'b101010,
		FN_SLTU    = 6'b101011
	} funct_e;

	typedef enum logic [2:0] {
		SEL_LOGIC       = 3'd1,
		SEL_SHIFT       = 3'd2,
		SEL_ARITH       = 3'd3,
		SEL_BRANCH_JUMP = 3'd4,
		SEL_TRAP        = 3'd5
	} alu_sel_e;

	// SPECIAL ops are {2'b00, funct}, primary ops {2'b01, opcode}, REGIMM {3'b100, rt}
	typedef enum logic [7:0] {
		ALU_SLL     = 8'h00,
		ALU_SRL     = 8'h02,
		ALU_SRA     = 8'h03,
		ALU_SLLV    = 8'h04,
		ALU_SRLV    = 8'h06,
		ALU_SRAV    = 8'h07,
		ALU_JR      = 8'h08,
		ALU_JALR    = 8'h09,
		ALU_SYSCALL = 8'h0c,
		ALU_BREAK   = 8'h0d,
		ALU_ADD     = 8'h20,
		ALU_ADDU    = 8'h21,
		ALU_SUB     = 8'h22,
		ALU_SUBU    = 8'h23,
		ALU_AND     = 8'h24,
		ALU_OR      = 8'h25,
		ALU_XOR     = 8'h26,
		ALU_NOR     = 8'h27,
		ALU_SLT     = 8'h2a,
		ALU_SLTU    = 8'h2b,
		ALU_J       = 8'h42,
		ALU_JAL     = 8'h43,
		ALU_BEQ     = 8'h44,
		ALU_BNE     = 8'h45,
		ALU_BLEZ    = 8'h46,
		ALU_BGTZ    = 8'h47,
		ALU_ADDI    = 8'h48,
		ALU_ADDIU   = 8'h49,
		ALU_SLTI    = 8'h4a,
		ALU_SLTIU   = 8'h4b,
		ALU_ANDI    = 8'h4c,
		ALU_ORI     = 8'h4d,
		ALU_XORI    = 8'h4e,
		ALU_LUI     = 8'h4f,
		ALU_BLTZ    = 8'h80,
		ALU_BGEZ    = 8'h81,
		ALU_BLTZAL  = 8'h90,
		ALU_BGEZAL  = 8'h91
	} alu_op_e;

	// Fetch may deliver other codes in the same field
	typedef enum logic [4:0] {
		EXC_SYS  = 5'h08,
		EXC_BP   = 5'h09,
		EXC_RI   = 5'h0a,
		EXC_NONE = 5'h1f
	} exc_code_e;

endpackage

`default_nettype wire

//--- decoder/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module inst_decoder (
	input  id_pkg::word_t     pc_i,
	input  id_pkg::word_t     inst_i,
	input  logic              in_delay_i,
	input  id_pkg::exc_code_e exc_code_i,
	output id_pkg::alu_sel_e  alu_sel_o,
	output id_pkg::alu_op_e   alu_op_o,
	output id_pkg::reg_addr_t wd_o,
	output logic              wreg_o,
	output logic              reg1_read_o,
	output id_pkg::reg_addr_t reg1_addr_o,
	output logic              reg2_read_o,
	output id_pkg::reg_addr_t reg2_addr_o,
	output id_pkg::word_t     imm_o,
	output logic              next_delay_o,
	output id_pkg::exc_code_e exc_code_o,
	output id_pkg::word_t     exc_epc_o
);
	import id_pkg::*;

	opcode_e   op;
	funct_e    funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	logic [4:0] sa;
	word_t     sa_imm;
	word_t     zero_imm;
	word_t     sign_imm;

	//////////////////////////////////////////////////////////////////////
	// Instruction fields
	//////////////////////////////////////////////////////////////////////

	assign op    = opcode_e'(inst_i[31:26]);
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign sa    = inst_i[10:6];
	assign funct = funct_e'(inst_i[5:0]);

	assign sa_imm   = {{(`ID_WORD_W-5){1'b0}}, sa};
	assign zero_imm = {{(`ID_WORD_W-16){1'b0}}, inst_i[15:0]};
	assign sign_imm = {{(`ID_WORD_W-16){inst_i[15]}}, inst_i[15:0]};

	// Faulting instruction in a delay slot restarts at its branch
	assign exc_epc_o = in_delay_i ? (pc_i - `ID_PC_STEP) : pc_i;

	//////////////////////////////////////////////////////////////////////
	// Control decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		alu_sel_o    = SEL_SHIFT;
		alu_op_o     = ALU_SLL;
		wd_o         = '0;
		wreg_o       = 1'b0;
		reg1_read_o  = 1'b0;
		reg1_addr_o  = '0;
		reg2_read_o  = 1'b0;
		reg2_addr_o  = '0;
		imm_o        = '0;
		next_delay_o = 1'b0;
		exc_code_o   = exc_code_i;

		// Fetch fault leaves the no-op in place
		if (exc_code_i == EXC_NONE) begin
			case (op)
				OP_SPECIAL: begin
					alu_op_o = alu_op_e'({2'b00, funct});
					case (funct)
						FN_AND, FN_OR, FN_XOR, FN_NOR,
						FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU: begin
							// funct 1001xx is the logic group
							alu_sel_o   = (funct[5:2] == 4'b1001) ? SEL_LOGIC : SEL_ARITH;
							wreg_o      = 1'b1;
							wd_o        = rd;
							reg1_read_o = 1'b1;
							reg1_addr_o = rs;
							reg2_read_o = 1'b1;
							reg2_addr_o = rt;
						end
						FN_SLL, FN_SRL, FN_SRA: begin
							wreg_o      = 1'b1;
							wd_o        = rd;
							reg1_read_o = 1'b1;
							reg1_addr_o = rt;
							imm_o       = sa_imm;
						end
						FN_SLLV, FN_SRLV, FN_SRAV: begin
							wreg_o      = 1'b1;
							wd_o        = rd;
							reg1_read_o = 1'b1;
							reg1_addr_o = rt;
							reg2_read_o = 1'b1;
							reg2_addr_o = rs;
						end
						FN_JR, FN_JALR: begin
							alu_sel_o    = SEL_BRANCH_JUMP;
							reg1_read_o  = 1'b1;
							reg1_addr_o  = rs;
							next_delay_o = 1'b1;
							if (funct == FN_JALR) begin
								wreg_o = 1'b1;
								wd_o   = rd;
							end
						end
						FN_SYSCALL, FN_BREAK: begin
							alu_sel_o  = SEL_TRAP;
							exc_code_o = (funct == FN_SYSCALL) ? EXC_SYS : EXC_BP;
						end
						default: begin
							alu_op_o   = ALU_SLL;
							exc_code_o = EXC_RI;
						end
					endcase
				end

				OP_ANDI, OP_ORI, OP_XORI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
					// Logic immediates are zero extended
					alu_sel_o   = op[2] ? SEL_LOGIC : SEL_ARITH;
					alu_op_o    = alu_op_e'({2'b01, op});
					wreg_o      = 1'b1;
					wd_o        = rt;
					reg1_read_o = 1'b1;
					reg1_addr_o = rs;
					imm_o       = op[2] ? zero_imm : sign_imm;
				end

				OP_LUI: begin
					alu_sel_o = SEL_LOGIC;
					alu_op_o  = ALU_LUI;
					wreg_o    = 1'b1;
					wd_o      = rt;
					imm_o     = zero_imm;
				end

				OP_J, OP_JAL: begin
					alu_sel_o    = SEL_BRANCH_JUMP;
					alu_op_o     = alu_op_e'({2'b01, op});
					next_delay_o = 1'b1;
					if (op == OP_JAL) begin
						wreg_o = 1'b1;
						wd_o   = `ID_LINK_REG;
					end
				end

				OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
					alu_sel_o    = SEL_BRANCH_JUMP;
					alu_op_o     = alu_op_e'({2'b01, op});
					reg1_read_o  = 1'b1;
					reg1_addr_o  = rs;
					next_delay_o = 1'b1;
					// Only BEQ and BNE compare two registers
					if (!op[1]) begin
						reg2_read_o = 1'b1;
						reg2_addr_o = rt;
					end
				end

				OP_REGIMM: begin
					case (rt)
						// BLTZ, BGEZ, BLTZAL, BGEZAL
						5'b00000, 5'b00001, 5'b10000, 5'b10001: begin
							alu_sel_o    = SEL_BRANCH_JUMP;
							alu_op_o     = alu_op_e'({3'b100, rt});
							reg1_read_o  = 1'b1;
							reg1_addr_o  = rs;
							next_delay_o = 1'b1;
							if (rt[4]) begin
								wreg_o = 1'b1;
								wd_o   = `ID_LINK_REG;
							end
						end
						default: exc_code_o = EXC_RI;
					endcase
				end

				default: exc_code_o = EXC_RI;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- decoder/branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_macros.svh"

module branch_resolve (
	input  id_pkg::alu_op_e alu_op_i,
	input  id_pkg::word_t   pc_i,
	input  id_pkg::word_t   inst_i,
	input  id_pkg::word_t   reg1_i,
	input  id_pkg::word_t   reg2_i,
	output logic            branch_flag_o,
	output id_pkg::word_t   branch_addr_o,
	output id_pkg::word_t   link_addr_o
);
	import id_pkg::*;

	word_t pc_4;
	word_t pc_8;
	word_t jump_target;
	word_t branch_target;
	word_t target;
	logic  taken;
	logic  reg1_neg;
	logic  reg1_zero;

	assign pc_4 = pc_i + `ID_PC_STEP;
	assign pc_8 = pc_4 + `ID_PC_STEP;

	// Region of the delay slot, not of the jump itself
	assign jump_target   = {pc_4[`ID_WORD_W-1:28], inst_i[25:0], 2'b00};
	assign branch_target = pc_4 + {{(`ID_WORD_W-18){inst_i[15]}}, inst_i[15:0], 2'b00};

	assign reg1_neg  = reg1_i[`ID_WORD_W-1];
	assign reg1_zero = (reg1_i == '0);

	always_comb begin
		target = branch_target;
		case (alu_op_i)
			ALU_J, ALU_JAL: begin
				taken  = 1'b1;
				target = jump_target;
			end
			ALU_JR, ALU_JALR: begin
				taken  = 1'b1;
				target = reg1_i;
			end
			ALU_BEQ:              taken = (reg1_i == reg2_i);
			ALU_BNE:              taken = (reg1_i != reg2_i);
			ALU_BGTZ:             taken = !reg1_neg && !reg1_zero;
			ALU_BLEZ:             taken = reg1_neg || reg1_zero;
			ALU_BLTZ, ALU_BLTZAL: taken = reg1_neg;
			ALU_BGEZ, ALU_BGEZAL: taken = !reg1_neg;
			default:              taken = 1'b0;
		endcase
	end

	assign branch_flag_o = taken;
	assign branch_addr_o = taken ? target : '0;

	// Return address skips the delay slot
	always_comb begin
		case (alu_op_i)
			ALU_JAL, ALU_JALR, ALU_BLTZAL, ALU_BGEZAL: link_addr_o = pc_8;
			default:                                   link_addr_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/operand_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fwd (
	input  logic              read_i,
	input  id_pkg::reg_addr_t addr_i,
	input  id_pkg::word_t     rf_data_i,
	input  id_pkg::word_t     imm_i,
	input  logic              ex_wreg_i,
	input  id_pkg::reg_addr_t ex_wd_i,
	input  id_pkg::word_t     ex_wdata_i,
	input  logic              mem_wreg_i,
	input  id_pkg::reg_addr_t mem_wd_i,
	input  id_pkg::word_t     mem_wdata_i,
	output id_pkg::word_t     operand_o
);

	// Youngest result wins
	always_comb begin
		if (!read_i)
			operand_o = imm_i;
		else if (ex_wreg_i && (ex_wd_i == addr_i))
			operand_o = ex_wdata_i;
		else if (mem_wreg_i && (mem_wd_i == addr_i))
			operand_o = mem_wdata_i;
		else
			operand_o = rf_data_i;
	end

endmodule

`default_nettype wire

//--- hw/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              stall_i,
	input  logic              valid_i,
	input  id_pkg::word_t     pc_i,
	input  id_pkg::word_t     inst_i,
	input  logic              in_delay_i,
	input  id_pkg::alu_sel_e  alu_sel_i,
	input  id_pkg::alu_op_e   alu_op_i,
	input  id_pkg::word_t     reg1_i,
	input  id_pkg::word_t     reg2_i,
	input  id_pkg::reg_addr_t wd_i,
	input  logic              wreg_i,
	input  id_pkg::word_t     link_addr_i,
	input  logic              next_delay_i,
	input  logic              branch_flag_i,
	input  id_pkg::word_t     branch_addr_i,
	input  id_pkg::exc_code_e exc_code_i,
	input  id_pkg::word_t     exc_epc_i,
	output logic              valid_o,
	output id_pkg::word_t     pc_o,
	output id_pkg::word_t     inst_o,
	output logic              in_delay_o,
	output id_pkg::alu_sel_e  alu_sel_o,
	output id_pkg::alu_op_e   alu_op_o,
	output id_pkg::word_t     reg1_o,
	output id_pkg::word_t     reg2_o,
	output id_pkg::reg_addr_t wd_o,
	output logic              wreg_o,
	output id_pkg::word_t     link_addr_o,
	output logic              next_delay_o,
	output logic              branch_flag_o,
	output id_pkg::word_t     branch_addr_o,
	output id_pkg::exc_code_e exc_code_o,
	output id_pkg::word_t     exc_epc_o
);
	import id_pkg::*;

	// Control fields, cleared to a no-op
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_o       <= 1'b0;
			in_delay_o    <= 1'b0;
			alu_sel_o     <= SEL_SHIFT;
			alu_op_o      <= ALU_SLL;
			wreg_o        <= 1'b0;
			next_delay_o  <= 1'b0;
			branch_flag_o <= 1'b0;
			exc_code_o    <= EXC_NONE;
		end else if (!stall_i) begin
			valid_o       <= valid_i;
			in_delay_o    <= in_delay_i;
			alu_sel_o     <= alu_sel_i;
			alu_op_o      <= alu_op_i;
			wreg_o        <= wreg_i;
			next_delay_o  <= next_delay_i;
			branch_flag_o <= branch_flag_i;
			exc_code_o    <= exc_code_i;
		end
	end

	// Payload
	always_ff @(posedge clk) begin
		if (!stall_i) begin
			pc_o          <= pc_i;
			inst_o        <= inst_i;
			reg1_o        <= reg1_i;
			reg2_o        <= reg2_i;
			wd_o          <= wd_i;
			link_addr_o   <= link_addr_i;
			branch_addr_o <= branch_addr_i;
			exc_epc_o     <= exc_epc_i;
		end
	end

endmodule

`default_nettype wire

//--- hw/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              stall_i,
	input  logic              valid_i,
	input  id_pkg::word_t     pc_i,
	input  id_pkg::word_t     inst_i,
	input  logic              in_delay_i,
	input  id_pkg::exc_code_e exc_code_i,
	// Register file
	input  id_pkg::word_t     reg1_data_i,
	input  id_pkg::word_t     reg2_data_i,
	output logic              reg1_read_o,
	output id_pkg::reg_addr_t reg1_addr_o,
	output logic              reg2_read_o,
	output id_pkg::reg_addr_t reg2_addr_o,
	// Forwarding
	input  logic              ex_wreg_i,
	input  id_pkg::reg_addr_t ex_wd_i,
	input  id_pkg::word_t     ex_wdata_i,
	input  logic              mem_wreg_i,
	input  id_pkg::reg_addr_t mem_wd_i,
	input  id_pkg::word_t     mem_wdata_i,
	// To execute
	output logic              valid_o,
	output id_pkg::word_t     pc_o,
	output id_pkg::word_t     inst_o,
	output logic              in_delay_o,
	output id_pkg::alu_sel_e  alu_sel_o,
	output id_pkg::alu_op_e   alu_op_o,
	output id_pkg::word_t     reg1_o,
	output id_pkg::word_t     reg2_o,
	output id_pkg::reg_addr_t wd_o,
	output logic              wreg_o,
	output id_pkg::word_t     link_addr_o,
	output logic              next_delay_o,
	output logic              branch_flag_o,
	output id_pkg::word_t     branch_addr_o,
	output id_pkg::exc_code_e exc_code_o,
	output id_pkg::word_t     exc_epc_o
);
	import id_pkg::*;

	alu_sel_e  dec_alu_sel;
	alu_op_e   dec_alu_op;
	reg_addr_t dec_wd;
	logic      dec_wreg;
	word_t     dec_imm;
	logic      dec_next_delay;
	exc_code_e dec_exc_code;
	word_t     dec_exc_epc;
	word_t     opnd1;
	word_t     opnd2;
	logic      br_flag;
	word_t     br_addr;
	word_t     br_link_addr;

	inst_decoder inst_decoder_inst (
		.pc_i         (pc_i),
		.inst_i       (inst_i),
		.in_delay_i   (in_delay_i),
		.exc_code_i   (exc_code_i),
		.alu_sel_o    (dec_alu_sel),
		.alu_op_o     (dec_alu_op),
		.wd_o         (dec_wd),
		.wreg_o       (dec_wreg),
		.reg1_read_o  (reg1_read_o),
		.reg1_addr_o  (reg1_addr_o),
		.reg2_read_o  (reg2_read_o),
		.reg2_addr_o  (reg2_addr_o),
		.imm_o        (dec_imm),
		.next_delay_o (dec_next_delay),
		.exc_code_o   (dec_exc_code),
		.exc_epc_o    (dec_exc_epc)
	);

	//////////////////////////////////////////////////////////////////////
	// Source operands
	//////////////////////////////////////////////////////////////////////

	operand_fwd operand_fwd_1 (
		.read_i      (reg1_read_o),
		.addr_i      (reg1_addr_o),
		.rf_data_i   (reg1_data_i),
		.imm_i       (dec_imm),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o   (opnd1)
	);

	operand_fwd operand_fwd_2 (
		.read_i      (reg2_read_o),
		.addr_i      (reg2_addr_o),
		.rf_data_i   (reg2_data_i),
		.imm_i       (dec_imm),
		.ex_wreg_i   (ex_wreg_i),
		.ex_wd_i     (ex_wd_i),
		.ex_wdata_i  (ex_wdata_i),
		.mem_wreg_i  (mem_wreg_i),
		.mem_wd_i    (mem_wd_i),
		.mem_wdata_i (mem_wdata_i),
		.operand_o   (opnd2)
	);

	branch_resolve branch_resolve_inst (
		.alu_op_i      (dec_alu_op),
		.pc_i          (pc_i),
		.inst_i        (inst_i),
		.reg1_i        (opnd1),
		.reg2_i        (opnd2),
		.branch_flag_o (br_flag),
		.branch_addr_o (br_addr),
		.link_addr_o   (br_link_addr)
	);

	//////////////////////////////////////////////////////////////////////
	// ID/EX boundary
	//////////////////////////////////////////////////////////////////////

	id_ex_reg id_ex_reg_inst (
		.clk           (clk),
		.rst_i         (rst_i),
		.stall_i       (stall_i),
		.valid_i       (valid_i),
		.pc_i          (pc_i),
		.inst_i        (inst_i),
		.in_delay_i    (in_delay_i),
		.alu_sel_i     (dec_alu_sel),
		.alu_op_i      (dec_alu_op),
		.reg1_i        (opnd1),
		.reg2_i        (opnd2),
		.wd_i          (dec_wd),
		.wreg_i        (dec_wreg),
		.link_addr_i   (br_link_addr),
		.next_delay_i  (dec_next_delay),
		.branch_flag_i (br_flag),
		.branch_addr_i (br_addr),
		.exc_code_i    (dec_exc_code),
		.exc_epc_i     (dec_exc_epc),
		.valid_o       (valid_o),
		.pc_o          (pc_o),
		.inst_o        (inst_o),
		.in_delay_o    (in_delay_o),
		.alu_sel_o     (alu_sel_o),
		.alu_op_o      (alu_op_o),
		.reg1_o        (reg1_o),
		.reg2_o        (reg2_o),
		.wd_o          (wd_o),
		.wreg_o        (wreg_o),
		.link_addr_o   (link_addr_o),
		.next_delay_o  (next_delay_o),
		.branch_flag_o (branch_flag_o),
		.branch_addr_o (branch_addr_o),
		.exc_code_o    (exc_code_o),
		.exc_epc_o     (exc_epc_o)
	);

endmodule

`default_nettype wire

//--- tb/id_ref_model.svh
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// Inputs applied to the DUT in one cycle
typedef struct {
	logic        valid;
	logic [31:0] pc;
	logic [31:0] inst;
	logic        in_delay;
	logic [4:0]  exc;
	logic        ex_wreg;
	logic [4:0]  ex_wd;
	logic [31:0] ex_wdata;
	logic        mem_wreg;
	logic [4:0]  mem_wd;
	logic [31:0] mem_wdata;
	logic        stall;
} stim_t;

// Expected registered outputs and register file read ports
typedef struct {
	logic        valid;
	logic [31:0] pc;
	logic [31:0] inst;
	logic        in_delay;
	logic [2:0]  alu_sel;
	logic [7:0]  alu_op;
	logic [31:0] reg1;
	logic [31:0] reg2;
	logic [4:0]  wd;
	logic        wreg;
	logic [31:0] link_addr;
	logic        next_delay;
	logic        branch_flag;
	logic [31:0] branch_addr;
	logic [4:0]  exc_code;
	logic [31:0] exc_epc;
	logic        reg1_read;
	logic [4:0]  reg1_addr;
	logic        reg2_read;
	logic [4:0]  reg2_addr;
} exp_t;

// Register file contents as a function of the address
function automatic logic [31:0] rf_hash(logic [4:0] addr);
	return ({27'd0, addr} * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
endfunction

function automatic logic [31:0] pick_operand(stim_t s, logic rd_en, logic [4:0] addr,
		logic [31:0] imm);
	if (!rd_en)
		return imm;
	if (s.ex_wreg && s.ex_wd == addr)
		return s.ex_wdata;
	if (s.mem_wreg && s.mem_wd == addr)
		return s.mem_wdata;
	return rf_hash(addr);
endfunction

function automatic exp_t decode_ref(stim_t s);
	exp_t        e;
	logic [5:0]  op;
	logic [5:0]  fn;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic        r1;
	logic        r2;
	logic [4:0]  a1;
	logic [4:0]  a2;
	logic [31:0] imm;
	logic [31:0] pc4;
	logic [31:0] target;
	logic        taken;
	op = s.inst[31:26];
	rs = s.inst[25:21];
	rt = s.inst[20:16];
	rd = s.inst[15:11];
	fn = s.inst[5:0];
	e.valid = s.valid;
	e.pc = s.pc;
	e.inst = s.inst;
	e.in_delay = s.in_delay;
	e.alu_sel = SEL_SHIFT;
	e.alu_op = ALU_SLL;
	e.wd = 5'd0;
	e.wreg = 1'b0;
	e.next_delay = 1'b0;
	e.exc_code = s.exc;
	e.exc_epc = s.in_delay ? s.pc - 32'd4 : s.pc;
	r1 = 1'b0;
	r2 = 1'b0;
	a1 = 5'd0;
	a2 = 5'd0;
	imm = 32'd0;
	if (s.exc == EXC_NONE) begin
		case (op)
			OP_SPECIAL: begin
				e.alu_op = {2'b00, fn};
				case (fn)
					FN_AND, FN_OR, FN_XOR, FN_NOR, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
					FN_SLT, FN_SLTU: begin
						e.alu_sel = (fn inside {FN_AND, FN_OR, FN_XOR, FN_NOR}) ?
							SEL_LOGIC : SEL_ARITH;
						e.wreg = 1'b1;
						e.wd = rd;
						r1 = 1'b1;
						a1 = rs;
						r2 = 1'b1;
						a2 = rt;
					end
					FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: begin
						e.wreg = 1'b1;
						e.wd = rd;
						r1 = 1'b1;
						a1 = rt;
						// Variable shifts take the amount from rs
						if (fn[2]) begin
							r2 = 1'b1;
							a2 = rs;
						end else begin
							imm = {27'd0, s.inst[10:6]};
						end
					end
					FN_JR, FN_JALR: begin
						e.alu_sel = SEL_BRANCH_JUMP;
						e.next_delay = 1'b1;
						r1 = 1'b1;
						a1 = rs;
						e.wreg = (fn == FN_JALR);
						e.wd = (fn == FN_JALR) ? rd : 5'd0;
					end
					FN_SYSCALL: begin
						e.alu_sel = SEL_TRAP;
						e.exc_code = EXC_SYS;
					end
					FN_BREAK: begin
						e.alu_sel = SEL_TRAP;
						e.exc_code = EXC_BP;
					end
					default: begin
						e.alu_op = ALU_SLL;
						e.exc_code = EXC_RI;
					end
				endcase
			end
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				e.alu_op = {2'b01, op};
				e.wreg = 1'b1;
				e.wd = rt;
				r1 = (op != OP_LUI);
				a1 = (op != OP_LUI) ? rs : 5'd0;
				if (op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI}) begin
					e.alu_sel = SEL_LOGIC;
					imm = {16'd0, s.inst[15:0]};
				end else begin
					e.alu_sel = SEL_ARITH;
					imm = {{16{s.inst[15]}}, s.inst[15:0]};
				end
			end
			OP_J, OP_JAL: begin
				e.alu_sel = SEL_BRANCH_JUMP;
				e.alu_op = {2'b01, op};
				e.next_delay = 1'b1;
				e.wreg = (op == OP_JAL);
				e.wd = (op == OP_JAL) ? 5'd31 : 5'd0;
			end
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
				e.alu_sel = SEL_BRANCH_JUMP;
				e.alu_op = {2'b01, op};
				e.next_delay = 1'b1;
				r1 = 1'b1;
				a1 = rs;
				r2 = (op == OP_BEQ || op == OP_BNE);
				a2 = r2 ? rt : 5'd0;
			end
			OP_REGIMM: begin
				if (rt inside {5'h00, 5'h01, 5'h10, 5'h11}) begin
					e.alu_sel = SEL_BRANCH_JUMP;
					e.alu_op = {3'b100, rt};
					e.next_delay = 1'b1;
					r1 = 1'b1;
					a1 = rs;
					e.wreg = rt[4];
					e.wd = rt[4] ? 5'd31 : 5'd0;
				end else begin
					e.exc_code = EXC_RI;
				end
			end
			default: e.exc_code = EXC_RI;
		endcase
	end
	e.reg1 = pick_operand(s, r1, a1, imm);
	e.reg2 = pick_operand(s, r2, a2, imm);
	e.reg1_read = r1;
	e.reg1_addr = a1;
	e.reg2_read = r2;
	e.reg2_addr = a2;

	// Branch outcome
	pc4 = s.pc + 32'd4;
	target = pc4 + {{14{s.inst[15]}}, s.inst[15:0], 2'b00};
	taken = 1'b0;
	case (e.alu_op)
		ALU_J, ALU_JAL: begin
			taken = 1'b1;
			target = {pc4[31:28], s.inst[25:0], 2'b00};
		end
		ALU_JR, ALU_JALR: begin
			taken = 1'b1;
			target = e.reg1;
		end
		ALU_BEQ: taken = (e.reg1 == e.reg2);
		ALU_BNE: taken = (e.reg1 != e.reg2);
		ALU_BGTZ: taken = ($signed(e.reg1) > 0);
		ALU_BLEZ: taken = ($signed(e.reg1) <= 0);
		ALU_BLTZ, ALU_BLTZAL: taken = ($signed(e.reg1) < 0);
		ALU_BGEZ, ALU_BGEZAL: taken = ($signed(e.reg1) >= 0);
		default: taken = 1'b0;
	endcase
	e.branch_flag = taken;
	e.branch_addr = taken ? target : 32'd0;
	e.link_addr = (e.alu_op inside {ALU_JAL, ALU_JALR, ALU_BLTZAL, ALU_BGEZAL}) ?
		s.pc + 32'd8 : 32'd0;
	return e;
endfunction

`endif

//--- tb/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb;
	import id_pkg::*;

	`include "id_ref_model.svh"

	logic      clk;
	logic      rst_i;
	logic      stall_i;
	logic      valid_i;
	word_t     pc_i;
	word_t     inst_i;
	logic      in_delay_i;
	exc_code_e exc_code_i;
	word_t     reg1_data_i;
	word_t     reg2_data_i;
	logic      reg1_read_o;
	reg_addr_t reg1_addr_o;
	logic      reg2_read_o;
	reg_addr_t reg2_addr_o;
	logic      ex_wreg_i;
	reg_addr_t ex_wd_i;
	word_t     ex_wdata_i;
	logic      mem_wreg_i;
	reg_addr_t mem_wd_i;
	word_t     mem_wdata_i;
	logic      valid_o;
	word_t     pc_o;
	word_t     inst_o;
	logic      in_delay_o;
	alu_sel_e  alu_sel_o;
	alu_op_e   alu_op_o;
	word_t     reg1_o;
	word_t     reg2_o;
	reg_addr_t wd_o;
	logic      wreg_o;
	word_t     link_addr_o;
	logic      next_delay_o;
	logic      branch_flag_o;
	word_t     branch_addr_o;
	exc_code_e exc_code_o;
	word_t     exc_epc_o;

	integer seed = 71357;
	int     cyc = 0;
	string  cur_test = "reset";
	exp_t   last_exp;
	exp_t   exp_q[$];
	string  name_q[$];
	int     due_q[$];
	exp_t   port_q[$];
	string  port_name_q[$];

	id_stage id_stage_inst (.*);

	// Register file answers in the same cycle
	assign reg1_data_i = rf_hash(reg1_addr_o);
	assign reg2_data_i = rf_hash(reg2_addr_o);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cyc = cyc + 1;

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_word(string test, string field, logic [31:0] exp, logic [31:0] act);
		assert (exp === act)
		else report_failure($sformatf("mismatch %s %s: expected %h, actual %h",
			test, field, exp, act));
	endtask

	task automatic compare_all(string t, exp_t e);
		check_word(t, "valid", 32'(e.valid), 32'(valid_o));
		check_word(t, "pc", e.pc, pc_o);
		check_word(t, "inst", e.inst, inst_o);
		check_word(t, "in_delay", 32'(e.in_delay), 32'(in_delay_o));
		check_word(t, "alu_sel", 32'(e.alu_sel), 32'(alu_sel_o));
		check_word(t, "alu_op", 32'(e.alu_op), 32'(alu_op_o));
		check_word(t, "reg1", e.reg1, reg1_o);
		check_word(t, "reg2", e.reg2, reg2_o);
		check_word(t, "wd", 32'(e.wd), 32'(wd_o));
		check_word(t, "wreg", 32'(e.wreg), 32'(wreg_o));
		check_word(t, "link_addr", e.link_addr, link_addr_o);
		check_word(t, "next_delay", 32'(e.next_delay), 32'(next_delay_o));
		check_word(t, "branch_flag", 32'(e.branch_flag), 32'(branch_flag_o));
		check_word(t, "branch_addr", e.branch_addr, branch_addr_o);
		check_word(t, "exc_code", 32'(e.exc_code), 32'(exc_code_o));
		check_word(t, "exc_epc", e.exc_epc, exc_epc_o);
	endtask

	task automatic compare_ports(string t, exp_t e);
		check_word(t, "reg1_read", 32'(e.reg1_read), 32'(reg1_read_o));
		check_word(t, "reg1_addr", 32'(e.reg1_addr), 32'(reg1_addr_o));
		check_word(t, "reg2_read", 32'(e.reg2_read), 32'(reg2_read_o));
		check_word(t, "reg2_addr", 32'(e.reg2_addr), 32'(reg2_addr_o));
	endtask

	// Everything is checked on the falling edge
	initial begin
		exp_t  e;
		string t;
		forever begin
			@(negedge clk);
			// Register file ports belong to the inputs of this cycle
			while (port_q.size() > 0) begin
				e = port_q.pop_front();
				t = port_name_q.pop_front();
				compare_ports(t, e);
			end
			// Registered results are due one edge after capture
			while (exp_q.size() > 0 && due_q[0] <= cyc) begin
				e = exp_q.pop_front();
				t = name_q.pop_front();
				void'(due_q.pop_front());
				compare_all(t, e);
			end
		end
	end

	task automatic apply(stim_t s);
		exp_t d;
		exp_t e;
		@(posedge clk);
		#1;
		valid_i     = s.valid;
		pc_i        = s.pc;
		inst_i      = s.inst;
		in_delay_i  = s.in_delay;
		exc_code_i  = exc_code_e'(s.exc);
		ex_wreg_i   = s.ex_wreg;
		ex_wd_i     = s.ex_wd;
		ex_wdata_i  = s.ex_wdata;
		mem_wreg_i  = s.mem_wreg;
		mem_wd_i    = s.mem_wd;
		mem_wdata_i = s.mem_wdata;
		stall_i     = s.stall;
		d = decode_ref(s);
		// A stalled edge keeps the previous capture
		if (s.stall)
			e = last_exp;
		else
			e = d;
		last_exp = e;
		port_q.push_back(d);
		port_name_q.push_back(cur_test);
		exp_q.push_back(e);
		name_q.push_back(cur_test);
		due_q.push_back(cyc + 1);
	endtask

	function automatic int rnd(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [31:0] edge_value();
		case (rnd(4))
			0: return 32'd0;
			1: return {1'b1, 31'($random(seed))};
			2: return {28'd0, 4'($random(seed))};
			default: return 32'($random(seed));
		endcase
	endfunction

	function automatic stim_t base_stim();
		stim_t s;
		s.valid     = 1'($random(seed));
		s.pc        = {30'($random(seed)), 2'b00};
		s.inst      = 32'd0;
		s.in_delay  = 1'($random(seed));
		s.exc       = EXC_NONE;
		s.ex_wreg   = 1'($random(seed));
		s.ex_wd     = 5'($random(seed));
		s.ex_wdata  = 32'($random(seed));
		s.mem_wreg  = 1'($random(seed));
		s.mem_wd    = 5'($random(seed));
		s.mem_wdata = 32'($random(seed));
		s.stall     = 1'b0;
		return s;
	endfunction

	function automatic logic [31:0] kept_alu_inst();
		logic [5:0] r_fn[16] = '{FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLL, FN_SRL, FN_SRA,
			FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
		logic [5:0] i_op[8] = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI, OP_ADDI, OP_ADDIU,
			OP_SLTI, OP_SLTIU};
		logic [31:0] w;
		w = 32'($random(seed));
		if (rnd(2) == 0)
			return {6'd0, w[25:6], r_fn[rnd(16)]};
		return {i_op[rnd(8)], w[25:0]};
	endfunction

	task automatic alu_decode_mix();
		stim_t s;
		cur_test = "alu_decode";
		repeat (80) begin
			s = base_stim();
			s.inst = kept_alu_inst();
			apply(s);
		end
	endtask

	task automatic forwarding_priority();
		stim_t s;
		cur_test = "forwarding";
		for (int mode = 0; mode < 4; mode++) begin
			repeat (10) begin
				s = base_stim();
				s.inst = {6'd0, 5'($random(seed)), 5'($random(seed)), 5'd3, 5'd0, FN_ADD};
				// Modes: ex only, mem only, both, none
				s.ex_wreg = (mode == 0 || mode == 2);
				s.mem_wreg = (mode == 1 || mode == 2);
				s.ex_wd = s.inst[25:21];
				s.mem_wd = s.inst[25:21];
				apply(s);
			end
		end
	endtask

	task automatic branch_mix();
		stim_t s;
		logic [31:0] w;
		cur_test = "branch_jump";
		repeat (120) begin
			s = base_stim();
			w = 32'($random(seed));
			case (rnd(5))
				0: s.inst = {(rnd(2) == 0) ? OP_J : OP_JAL, w[25:0]};
				1: s.inst = {6'd0, w[25:21], 5'd0, w[15:11], 5'd0,
					(rnd(2) == 0) ? FN_JR : FN_JALR};
				2: s.inst = {4'b0001, 2'(rnd(4)), w[25:0]};
				default: s.inst = {OP_REGIMM, w[25:21], rt_of(rnd(4)), w[15:0]};
			endcase
			if (rnd(4) == 0)
				s.inst[20:16] = s.inst[25:21];
			s.ex_wreg = 1'b1;
			s.ex_wd = s.inst[25:21];
			s.ex_wdata = edge_value();
			s.mem_wreg = 1'b1;
			s.mem_wd = s.inst[20:16];
			s.mem_wdata = (rnd(3) == 0) ? s.ex_wdata : edge_value();
			apply(s);
		end
	endtask

	function automatic logic [4:0] rt_of(int k);
		logic [4:0] codes[4] = '{5'h00, 5'h01, 5'h10, 5'h11};
		return codes[k];
	endfunction

	task automatic exception_mix();
		stim_t s;
		logic [31:0] bad[8] = '{32'h8c22_0004, 32'hac22_0004, 32'h4080_6000, 32'h7000_0002,
			32'h0000_0010, 32'h0022_0018, 32'h0402_0000, 32'h4200_0018};
		logic [4:0] fetch_exc[3] = '{5'h00, 5'h04, 5'h05};
		cur_test = "exceptions";
		repeat (60) begin
			s = base_stim();
			case (rnd(3))
				0: s.inst = bad[rnd(8)];
				1: s.inst = {6'd0, 20'($random(seed)), (rnd(2) == 0) ? FN_SYSCALL : FN_BREAK};
				default: begin
					s.inst = kept_alu_inst();
					s.exc = fetch_exc[rnd(3)];
				end
			endcase
			apply(s);
		end
	endtask

	task automatic stall_hold();
		stim_t s;
		cur_test = "stall";
		repeat (10) begin
			s = base_stim();
			s.inst = kept_alu_inst();
			apply(s);
			repeat (3) begin
				s = base_stim();
				s.inst = kept_alu_inst();
				s.stall = 1'b1;
				apply(s);
			end
		end
	endtask

	initial begin
		int n;
		rst_i = 1'b1;
		stall_i = 1'b0;
		valid_i = 1'b0;
		pc_i = '0;
		inst_i = '0;
		in_delay_i = 1'b0;
		exc_code_i = EXC_NONE;
		ex_wreg_i = 1'b0;
		ex_wd_i = '0;
		ex_wdata_i = '0;
		mem_wreg_i = 1'b0;
		mem_wd_i = '0;
		mem_wdata_i = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_i = 1'b0;
		check_word("reset", "valid", 32'd0, 32'(valid_o));
		check_word("reset", "wreg", 32'd0, 32'(wreg_o));
		check_word("reset", "branch_flag", 32'd0, 32'(branch_flag_o));
		check_word("reset", "next_delay", 32'd0, 32'(next_delay_o));
		check_word("reset", "exc_code", 32'(EXC_NONE), 32'(exc_code_o));
		check_word("reset", "alu_op", 32'(ALU_SLL), 32'(alu_op_o));

		alu_decode_mix();
		forwarding_priority();
		branch_mix();
		exception_mix();
		stall_hold();

		n = 0;
		while (exp_q.size() > 0 && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() > 0) begin
			report_failure("timeout: expected results still pending at the end of the run");
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+common
+incdir+tb
common/id_pkg.sv
decoder/inst_decoder.sv
decoder/branch_resolve.sv
hw/operand_fwd.sv
hw/id_ex_reg.sv
hw/id_stage.sv
tb/id_stage_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module id_stage_tb \
	-f all.f --Mdir obj_dir -o id_stage_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/id_stage_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
